// ==== dv/bridge_tb.sv ====
// acts as NoC source and sink and as the remote link peer; fixed seed, stops at the first error
`timescale 1ns/100ps
`include "bridge_defs.svh"

module bridge_tb
  import bridge_flit_pkg::*;
  import bridge_link_pkg::*;
();

  localparam int N_FLITS        = 40;
  localparam int M_WORDS        = 40;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = 20 * (2 * N_FLITS + 2 * M_WORDS) + RESET_CYCLES;

  logic         clk_i;
  logic         rst_n_i;
  logic         narrow_valid_i;
  narrow_data_t narrow_data_i;
  logic         narrow_ready_o;
  logic         wide_valid_i;
  wide_data_t   wide_data_i;
  logic         wide_ready_o;
  logic         narrow_valid_o;
  narrow_data_t narrow_data_o;
  logic         narrow_ready_i;
  logic         wide_valid_o;
  wide_data_t   wide_data_o;
  logic         wide_ready_i;
  logic         axis_out_tvalid_o;
  link_data_t   axis_out_tdata_o;
  link_user_t   axis_out_tuser_o;
  logic         axis_out_tready_i;
  logic         axis_in_tvalid_i;
  link_data_t   axis_in_tdata_i;
  link_user_t   axis_in_tuser_i;
  logic         axis_in_tready_o;

  // scoreboard
  link_data_t   exp_out_n [$];
  link_data_t   exp_out_w [$];
  narrow_data_t exp_in_n [$];
  wide_data_t   exp_in_w [$];
  link_data_t   held_data;
  link_user_t   held_user;
  logic         hold_pending;
  logic         narrow_acc;
  logic         wide_acc;
  logic [31:0]  rng_state;
  int noc_n_sent;
  int noc_w_sent;
  int out_n_seen;
  int out_w_seen;
  int tb_ret_n;
  int tb_ret_w;
  int peer_n_sent;
  int peer_w_sent;
  int in_n_got;
  int in_w_got;
  int dut_ret_n;
  int dut_ret_w;
  int cycle_cnt;

  noc_axis_bridge dut0 (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .narrow_valid_i (narrow_valid_i), .narrow_data_i (narrow_data_i),
    .narrow_ready_o (narrow_ready_o),
    .wide_valid_i (wide_valid_i), .wide_data_i (wide_data_i), .wide_ready_o (wide_ready_o),
    .narrow_valid_o (narrow_valid_o), .narrow_data_o (narrow_data_o),
    .narrow_ready_i (narrow_ready_i),
    .wide_valid_o (wide_valid_o), .wide_data_o (wide_data_o), .wide_ready_i (wide_ready_i),
    .axis_out_tvalid_o (axis_out_tvalid_o), .axis_out_tdata_o (axis_out_tdata_o),
    .axis_out_tuser_o (axis_out_tuser_o), .axis_out_tready_i (axis_out_tready_i),
    .axis_in_tvalid_i (axis_in_tvalid_i), .axis_in_tdata_i (axis_in_tdata_i),
    .axis_in_tuser_i (axis_in_tuser_i), .axis_in_tready_o (axis_in_tready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // stream word: payload, zero-extended for narrow, then the data header
  function automatic link_data_t pack_word(input wide_data_t payload, input chan_e hdr);
    return {payload, hdr};
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_narrow(input string name, input narrow_data_t got, input narrow_data_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_wide(input string name, input wide_data_t got, input wide_data_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_link(input string name, input link_data_t got, input link_data_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_user(input string name, input link_user_t got, input link_user_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // credit results are bounds, not exact values
  task automatic check_credit(input string name, input credit_t got, input credit_t limit);
    if ($isunknown(got) || got > limit) begin
      stop_with_error($sformatf("error: %s is 0x%0h, limit 0x%0h", name, got, limit));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sampling at the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic take_out_word();
    link_data_t exp_word;
    credit_t    cred;
    cred = axis_out_tuser_o[`CRED_W-1:0];
    if (chan_e'(axis_out_tuser_o[`CRED_W]) == CHAN_NARROW) begin
      check_credit("narrow credits on axis_out_tuser_o", cred, credit_t'(in_n_got - dut_ret_n));
      dut_ret_n += cred;
    end else begin
      check_credit("wide credits on axis_out_tuser_o", cred, credit_t'(in_w_got - dut_ret_w));
      dut_ret_w += cred;
    end
    if (axis_out_tuser_o[`CRED_W+1]) begin
      if (chan_e'(axis_out_tdata_o[0]) == CHAN_NARROW) begin
        if (exp_out_n.size() == 0) begin
          stop_with_error("narrow data word on axis_out with no narrow flit pending");
        end
        exp_word = exp_out_n.pop_front();
        check_link("axis_out_tdata_o", axis_out_tdata_o, exp_word);
        out_n_seen++;
        check_credit("narrow words in flight", credit_t'(out_n_seen - tb_ret_n),
                     credit_t'(`NUM_CRED_NARROW));
      end else begin
        if (exp_out_w.size() == 0) begin
          stop_with_error("wide data word on axis_out with no wide flit pending");
        end
        exp_word = exp_out_w.pop_front();
        check_link("axis_out_tdata_o", axis_out_tdata_o, exp_word);
        out_w_seen++;
        check_credit("wide words in flight", credit_t'(out_w_seen - tb_ret_w),
                     credit_t'(`NUM_CRED_WIDE));
      end
    end
  endtask

  task automatic sample_cycle();
    narrow_data_t exp_n;
    wide_data_t   exp_w;
    @(negedge clk_i);
    narrow_acc = narrow_valid_i && narrow_ready_o;
    wide_acc   = wide_valid_i && wide_ready_o;
    if (narrow_acc) begin
      exp_out_n.push_back(pack_word(wide_data_t'(narrow_data_i), CHAN_NARROW));
      noc_n_sent++;
    end
    if (wide_acc) begin
      exp_out_w.push_back(pack_word(wide_data_i, CHAN_WIDE));
      noc_w_sent++;
    end
    // a stalled word must stay put
    if (hold_pending) begin
      if (!axis_out_tvalid_o) begin
        stop_with_error("axis_out_tvalid_o dropped before the word was accepted");
      end
      check_link("axis_out_tdata_o", axis_out_tdata_o, held_data);
      check_user("axis_out_tuser_o", axis_out_tuser_o, held_user);
    end
    hold_pending = axis_out_tvalid_o && !axis_out_tready_i;
    held_data    = axis_out_tdata_o;
    held_user    = axis_out_tuser_o;
    if (axis_out_tvalid_o && axis_out_tready_i) begin
      take_out_word();
    end
    // inbound word from the peer side
    if (axis_in_tvalid_i) begin
      if (!axis_in_tready_o) begin
        stop_with_error("axis_in_tready_o was low for a word sent within credits");
      end
      if (chan_e'(axis_in_tuser_i[`CRED_W]) == CHAN_NARROW) begin
        tb_ret_n += axis_in_tuser_i[`CRED_W-1:0];
      end else begin
        tb_ret_w += axis_in_tuser_i[`CRED_W-1:0];
      end
      if (axis_in_tuser_i[`CRED_W+1] && chan_e'(axis_in_tdata_i[0]) == CHAN_NARROW) begin
        exp_in_n.push_back(axis_in_tdata_i[`NARROW_W:1]);
        peer_n_sent++;
      end else if (axis_in_tuser_i[`CRED_W+1]) begin
        exp_in_w.push_back(axis_in_tdata_i[`WIDE_W:1]);
        peer_w_sent++;
      end
    end
    if (narrow_valid_o && narrow_ready_i) begin
      if (exp_in_n.size() == 0) begin
        stop_with_error("narrow_valid_o raised with no inbound narrow word pending");
      end
      exp_n = exp_in_n.pop_front();
      check_narrow("narrow_data_o", narrow_data_o, exp_n);
      in_n_got++;
    end
    if (wide_valid_o && wide_ready_i) begin
      if (exp_in_w.size() == 0) begin
        stop_with_error("wide_valid_o raised with no inbound wide word pending");
      end
      exp_w = exp_in_w.pop_front();
      check_wide("wide_data_o", wide_data_o, exp_w);
      in_w_got++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // driving 1 ns after the rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_cycle();
    logic [31:0] r;
    int          peer_cred_n;
    int          peer_cred_w;
    int          owed_n;
    int          owed_w;
    logic        send_n;
    logic        send_w;
    chan_e       cred_hdr;
    credit_t     cred;
    @(posedge clk_i);
    #1;
    r = next_random();
    // a raised flit holds until it is taken
    if (!narrow_valid_i || narrow_acc) begin
      narrow_valid_i = (noc_n_sent < N_FLITS) && r[0];
      narrow_data_i  = next_random();
    end
    if (!wide_valid_i || wide_acc) begin
      wide_valid_i = (noc_w_sent < N_FLITS) && r[1];
      wide_data_i  = {next_random(), next_random()};
    end
    axis_out_tready_i = (r[3:2] != 2'b00);
    narrow_ready_i    = (r[5:4] != 2'b00);
    wide_ready_i      = (r[7:6] != 2'b00);
    // peer sends data only with credits in hand
    peer_cred_n = `NUM_CRED_NARROW - peer_n_sent + dut_ret_n;
    peer_cred_w = `NUM_CRED_WIDE - peer_w_sent + dut_ret_w;
    owed_n      = out_n_seen - tb_ret_n;
    owed_w      = out_w_seen - tb_ret_w;
    cred_hdr    = (owed_w > owed_n) ? CHAN_WIDE : CHAN_NARROW;
    cred        = credit_t'((cred_hdr == CHAN_WIDE) ? owed_w : owed_n);
    send_n      = (peer_n_sent < M_WORDS) && (peer_cred_n > 0) && r[8];
    send_w      = !send_n && (peer_w_sent < M_WORDS) && (peer_cred_w > 0) && r[9];
    axis_in_tvalid_i = send_n || send_w || (cred != 0 && (cred >= `FORCE_SEND_THRESH || r[10]));
    axis_in_tuser_i  = {send_n || send_w, cred_hdr, cred};
    if (send_w) begin
      axis_in_tdata_i = pack_word({next_random(), next_random()}, CHAN_WIDE);
    end else begin
      axis_in_tdata_i = pack_word(wide_data_t'(next_random()), CHAN_NARROW);
    end
  endtask

  function automatic logic run_done();
    return noc_n_sent == N_FLITS && noc_w_sent == N_FLITS
        && out_n_seen == N_FLITS && out_w_seen == N_FLITS
        && in_n_got == M_WORDS && in_w_got == M_WORDS
        && (in_n_got - dut_ret_n) < `FORCE_SEND_THRESH
        && (in_w_got - dut_ret_w) < `FORCE_SEND_THRESH
        && !axis_out_tvalid_o;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n_i           = 1'b0;
    narrow_valid_i    = 1'b0;
    narrow_data_i     = '0;
    wide_valid_i      = 1'b0;
    wide_data_i       = '0;
    narrow_ready_i    = 1'b0;
    wide_ready_i      = 1'b0;
    axis_out_tready_i = 1'b0;
    axis_in_tvalid_i  = 1'b0;
    axis_in_tdata_i   = '0;
    axis_in_tuser_i   = '0;
    rng_state         = 32'h54f103be;
    hold_pending      = 1'b0;
    narrow_acc        = 1'b0;
    wide_acc          = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    // runs until all traffic is through and only a leftover below the force threshold is owed
    while (!run_done()) begin
      sample_cycle();
      drive_cycle();
    end
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles with traffic or owed credits still pending", cycle_cnt);
    $display("Simulation failed");
    $fatal(1, "run did not finish in time");
  end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/bridge_flit_pkg.sv
verilog/bridge_link_pkg.sv
verilog/stream_queue.sv
verilog/credit_channel.sv
verilog/link_tx.sv
verilog/link_rx.sv
verilog/noc_axis_bridge.sv
dv/bridge_tb.sv

// ==== verilog/bridge_defs.svh ====
// widths and credit counts are shared by both link ends; WIDE_W must be at least NARROW_W
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// payload widths
////////////////////////////////////////////////////////////////////////////

`define NARROW_W 32
`define WIDE_W 64

////////////////////////////////////////////////////////////////////////////
// credit flow control
////////////////////////////////////////////////////////////////////////////

// credit field on the stream user bits, holds counts up to 15
`define CRED_W 4
// initial send credits, also the depth of the inbound queue
`define NUM_CRED_NARROW 4
`define NUM_CRED_WIDE 4
// owed credits that trigger a credit-only word
`define FORCE_SEND_THRESH 2

`endif

// ==== verilog/bridge_flit_pkg.sv ====
// flit payload and credit types; widths come from bridge_defs.svh on the include path
`include "bridge_defs.svh"

package bridge_flit_pkg;

  // narrow flit payload
  typedef logic [`NARROW_W-1:0] narrow_data_t;

  // wide flit payload, also the payload part of a stream word
  typedef logic [`WIDE_W-1:0] wide_data_t;

  // credit count, both for send credits and owed credits
  typedef logic [`CRED_W-1:0] credit_t;

endpackage

// ==== verilog/bridge_link_pkg.sv ====
// stream word layout: tdata is {payload, data header}, tuser is {validity, credit header, credits}
`include "bridge_defs.svh"

package bridge_link_pkg;

  // channel header, used for both the data and the credit header
  typedef enum logic {
    CHAN_NARROW = 1'b0,
    CHAN_WIDE   = 1'b1
  } chan_e;

  // tdata: zero-extended payload followed by the data header bit
  typedef logic [`WIDE_W:0] link_data_t;

  // tuser: validity bit, credit header bit, returned credits
  typedef logic [`CRED_W+1:0] link_user_t;

  // narrow over wide arbitration
  typedef enum logic {
    SEL_NARROW,
    SEL_WIDE
  } sel_state_e;

endpackage

// ==== verilog/credit_channel.sv ====
// one per virtual channel; the peer must never return more credits than NUM_CRED in flight
`timescale 1ns/100ps
`include "bridge_defs.svh"

module credit_channel
  import bridge_flit_pkg::*;
#(
  parameter int NUM_CRED = 4
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // local flit waiting to go out
  input  logic    flit_valid_i,
  input  logic    sent_i,
  // credits returned by the far side
  input  logic    cred_in_valid_i,
  input  credit_t cred_in_i,
  // local flit delivered to the NoC, frees one slot of the inbound queue
  input  logic    flit_taken_i,
  input  logic    owed_sent_i,
  output logic    send_valid_o,
  output credit_t owed_o,
  output logic    force_send_o
);

  credit_t credit_q;
  credit_t credit_d;
  credit_t owed_q;
  credit_t owed_d;

  ////////////////////////////////////////////////////////////////////////////
  // send credits
  ////////////////////////////////////////////////////////////////////////////

  // a flit is only offered while the far queue has room
  assign send_valid_o = flit_valid_i && (credit_q != '0);

  always_comb begin
    credit_d = credit_q - credit_t'(sent_i);
    if (cred_in_valid_i) begin
      credit_d = credit_d + cred_in_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= credit_t'(NUM_CRED);
    end else begin
      credit_q <= credit_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // owed credits
  ////////////////////////////////////////////////////////////////////////////

  // the count carried by the outgoing word is dropped, a new take still counts
  always_comb begin
    if (owed_sent_i) begin
      owed_d = credit_t'(flit_taken_i);
    end else begin
      owed_d = owed_q + credit_t'(flit_taken_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owed_q <= '0;
    end else begin
      owed_q <= owed_d;
    end
  end

  assign owed_o       = owed_q;
  assign force_send_o = (owed_q >= credit_t'(`FORCE_SEND_THRESH));

  // an underflow wraps to a count above NUM_CRED as well
  property credit_in_range_p;
    @(posedge clk_i) disable iff (!rst_n_i)
      credit_q <= credit_t'(NUM_CRED);
  endproperty
  credit_in_range_a: assert property (credit_in_range_p);

endmodule

// ==== verilog/link_rx.sv ====
// the peer may only send data words for channels it holds credits for, otherwise tready drops
`timescale 1ns/100ps
`include "bridge_defs.svh"

module link_rx
  import bridge_flit_pkg::*;
  import bridge_link_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         axis_in_tvalid_i,
  input  link_data_t   axis_in_tdata_i,
  input  link_user_t   axis_in_tuser_i,
  output logic         axis_in_tready_o,
  output logic         narrow_valid_o,
  output narrow_data_t narrow_data_o,
  input  logic         narrow_ready_i,
  output logic         wide_valid_o,
  output wide_data_t   wide_data_o,
  input  logic         wide_ready_i,
  output logic         narrow_cred_valid_o,
  output logic         wide_cred_valid_o,
  output credit_t      cred_o
);

  wide_data_t payload;
  chan_e      data_hdr;
  chan_e      cred_hdr;
  logic       data_valid;
  logic       narrow_push;
  logic       wide_push;
  logic       narrow_q_ready;
  logic       wide_q_ready;

  // unpack
  assign payload    = axis_in_tdata_i[`WIDE_W:1];
  assign data_hdr   = chan_e'(axis_in_tdata_i[0]);
  assign data_valid = axis_in_tuser_i[`CRED_W+1];
  assign cred_hdr   = chan_e'(axis_in_tuser_i[`CRED_W]);
  assign cred_o     = axis_in_tuser_i[`CRED_W-1:0];

  // route data words by header
  assign narrow_push = axis_in_tvalid_i && data_valid && (data_hdr == CHAN_NARROW);
  assign wide_push   = axis_in_tvalid_i && data_valid && (data_hdr == CHAN_WIDE);

  // credit-only words never wait
  assign axis_in_tready_o = (narrow_push && narrow_q_ready) || (wide_push && wide_q_ready)
                         || (axis_in_tvalid_i && !data_valid);

  assign narrow_cred_valid_o = axis_in_tvalid_i && axis_in_tready_o && (cred_hdr == CHAN_NARROW);
  assign wide_cred_valid_o   = axis_in_tvalid_i && axis_in_tready_o && (cred_hdr == CHAN_WIDE);

  stream_queue #(
    .DEPTH (`NUM_CRED_NARROW),
    .WIDTH (`NARROW_W)
  ) narrow_q (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (narrow_push),
    .data_i  (payload[`NARROW_W-1:0]),
    .ready_o (narrow_q_ready),
    .valid_o (narrow_valid_o),
    .data_o  (narrow_data_o),
    .ready_i (narrow_ready_i)
  );

  stream_queue #(
    .DEPTH (`NUM_CRED_WIDE),
    .WIDTH (`WIDE_W)
  ) wide_q (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (wide_push),
    .data_i  (payload),
    .ready_o (wide_q_ready),
    .valid_o (wide_valid_o),
    .data_o  (wide_data_o),
    .ready_i (wide_ready_i)
  );

  // holds as long as the far credit counters mirror these queue depths
  axis_in_accept_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axis_in_tvalid_i |-> axis_in_tready_o);

endmodule

// ==== verilog/link_tx.sv ====
// narrow has priority over wide; the returned credit channel is the one owed more, narrow on a tie
`timescale 1ns/100ps

module link_tx
  import bridge_flit_pkg::*;
  import bridge_link_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         narrow_valid_i,
  input  narrow_data_t narrow_data_i,
  input  logic         wide_valid_i,
  input  wide_data_t   wide_data_i,
  input  credit_t      narrow_owed_i,
  input  credit_t      wide_owed_i,
  input  logic         narrow_force_i,
  input  logic         wide_force_i,
  output logic         narrow_sent_o,
  output logic         wide_sent_o,
  output logic         narrow_owed_sent_o,
  output logic         wide_owed_sent_o,
  output logic         axis_out_tvalid_o,
  output link_data_t   axis_out_tdata_o,
  output link_user_t   axis_out_tuser_o,
  input  logic         axis_out_tready_i
);

  localparam int Q_W = $bits(link_data_t) + $bits(link_user_t);

  sel_state_e sel_q;
  sel_state_e sel_d;
  chan_e      cred_hdr;
  credit_t    cred_val;
  logic       cand_valid;
  logic       cred_only;
  logic       q_valid;
  logic       q_ready;
  logic       push;
  link_data_t word_data;
  link_user_t word_user;
  logic [Q_W-1:0] q_data_out;

  ////////////////////////////////////////////////////////////////////////////
  // credit channel and channel arbitration
  ////////////////////////////////////////////////////////////////////////////

  assign cred_hdr = (wide_owed_i > narrow_owed_i) ? CHAN_WIDE : CHAN_NARROW;
  assign cred_val = (cred_hdr == CHAN_WIDE) ? wide_owed_i : narrow_owed_i;

  always_comb begin
    sel_d      = sel_q;
    cand_valid = 1'b0;
    word_data  = '0;
    case (sel_q)
      SEL_NARROW: begin
        cand_valid = narrow_valid_i;
        word_data  = {wide_data_t'(narrow_data_i), CHAN_NARROW};
        if (wide_valid_i && !narrow_valid_i) begin
          sel_d = SEL_WIDE;
        end
      end
      default: begin
        cand_valid = wide_valid_i;
        word_data  = {wide_data_i, CHAN_WIDE};
        // hand back once wide is idle or its word just went in
        if ((!wide_valid_i || q_ready) && narrow_valid_i) begin
          sel_d = SEL_NARROW;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= SEL_NARROW;
    end else begin
      sel_q <= sel_d;
    end
  end

  // credit-only word when no data waits and too much is owed
  assign cred_only = !narrow_valid_i && !wide_valid_i && (narrow_force_i || wide_force_i);
  assign q_valid   = cand_valid || cred_only;
  assign push      = q_valid && q_ready;
  assign word_user = {cand_valid, cred_hdr, cred_val};

  assign narrow_sent_o      = push && cand_valid && (sel_q == SEL_NARROW);
  assign wide_sent_o        = push && cand_valid && (sel_q == SEL_WIDE);
  assign narrow_owed_sent_o = push && (cred_hdr == CHAN_NARROW);
  assign wide_owed_sent_o   = push && (cred_hdr == CHAN_WIDE);

  ////////////////////////////////////////////////////////////////////////////
  // output queue
  ////////////////////////////////////////////////////////////////////////////

  stream_queue #(
    .DEPTH (2),
    .WIDTH (Q_W)
  ) out_q (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (q_valid),
    .data_i  ({word_data, word_user}),
    .ready_o (q_ready),
    .valid_o (axis_out_tvalid_o),
    .data_o  (q_data_out),
    .ready_i (axis_out_tready_i)
  );

  assign {axis_out_tdata_o, axis_out_tuser_o} = q_data_out;

  axis_out_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axis_out_tvalid_o && !axis_out_tready_i |=> axis_out_tvalid_o
      && $stable(axis_out_tdata_o) && $stable(axis_out_tuser_o));

endmodule

// ==== verilog/noc_axis_bridge.sv ====
// both link ends must use the same bridge_defs.svh so credit counts match the queue depths
`timescale 1ns/100ps
`include "bridge_defs.svh"

module noc_axis_bridge
  import bridge_flit_pkg::*;
  import bridge_link_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  // NoC flits into the bridge
  input  logic         narrow_valid_i,
  input  narrow_data_t narrow_data_i,
  output logic         narrow_ready_o,
  input  logic         wide_valid_i,
  input  wide_data_t   wide_data_i,
  output logic         wide_ready_o,
  // NoC flits out of the bridge
  output logic         narrow_valid_o,
  output narrow_data_t narrow_data_o,
  input  logic         narrow_ready_i,
  output logic         wide_valid_o,
  output wide_data_t   wide_data_o,
  input  logic         wide_ready_i,
  // outbound stream
  output logic         axis_out_tvalid_o,
  output link_data_t   axis_out_tdata_o,
  output link_user_t   axis_out_tuser_o,
  input  logic         axis_out_tready_i,
  // inbound stream
  input  logic         axis_in_tvalid_i,
  input  link_data_t   axis_in_tdata_i,
  input  link_user_t   axis_in_tuser_i,
  output logic         axis_in_tready_o
);

  logic    narrow_send_valid;
  logic    wide_send_valid;
  credit_t narrow_owed;
  credit_t wide_owed;
  logic    narrow_force;
  logic    wide_force;
  logic    narrow_owed_sent;
  logic    wide_owed_sent;
  logic    narrow_cred_valid;
  logic    wide_cred_valid;
  credit_t cred_in;
  logic    narrow_taken;
  logic    wide_taken;

  assign narrow_taken = narrow_valid_o && narrow_ready_i;
  assign wide_taken   = wide_valid_o && wide_ready_i;

  credit_channel #(.NUM_CRED(`NUM_CRED_NARROW)) narrow_cc (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .flit_valid_i (narrow_valid_i), .sent_i (narrow_ready_o),
    .cred_in_valid_i (narrow_cred_valid), .cred_in_i (cred_in),
    .flit_taken_i (narrow_taken), .owed_sent_i (narrow_owed_sent),
    .send_valid_o (narrow_send_valid), .owed_o (narrow_owed), .force_send_o (narrow_force)
  );

  credit_channel #(.NUM_CRED(`NUM_CRED_WIDE)) wide_cc (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .flit_valid_i (wide_valid_i), .sent_i (wide_ready_o),
    .cred_in_valid_i (wide_cred_valid), .cred_in_i (cred_in),
    .flit_taken_i (wide_taken), .owed_sent_i (wide_owed_sent),
    .send_valid_o (wide_send_valid), .owed_o (wide_owed), .force_send_o (wide_force)
  );

  link_tx tx (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .narrow_valid_i (narrow_send_valid), .narrow_data_i (narrow_data_i),
    .wide_valid_i (wide_send_valid), .wide_data_i (wide_data_i),
    .narrow_owed_i (narrow_owed), .wide_owed_i (wide_owed),
    .narrow_force_i (narrow_force), .wide_force_i (wide_force),
    .narrow_sent_o (narrow_ready_o), .wide_sent_o (wide_ready_o),
    .narrow_owed_sent_o (narrow_owed_sent), .wide_owed_sent_o (wide_owed_sent),
    .axis_out_tvalid_o (axis_out_tvalid_o), .axis_out_tdata_o (axis_out_tdata_o),
    .axis_out_tuser_o (axis_out_tuser_o), .axis_out_tready_i (axis_out_tready_i)
  );

  link_rx rx (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .axis_in_tvalid_i (axis_in_tvalid_i), .axis_in_tdata_i (axis_in_tdata_i),
    .axis_in_tuser_i (axis_in_tuser_i), .axis_in_tready_o (axis_in_tready_o),
    .narrow_valid_o (narrow_valid_o), .narrow_data_o (narrow_data_o),
    .narrow_ready_i (narrow_ready_i),
    .wide_valid_o (wide_valid_o), .wide_data_o (wide_data_o), .wide_ready_i (wide_ready_i),
    .narrow_cred_valid_o (narrow_cred_valid), .wide_cred_valid_o (wide_cred_valid),
    .cred_o (cred_in)
  );

endmodule

// ==== verilog/stream_queue.sv ====
// valid/ready FIFO, no push while full, no bypass so data_o is always registered
`timescale 1ns/100ps

module stream_queue #(
  parameter int DEPTH = 2,
  parameter int WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             valid_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             ready_o,
  output logic             valid_o,
  output logic [WIDTH-1:0] data_o,
  input  logic             ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full    = (cnt_q == CNT_W'(DEPTH));
  assign empty   = (cnt_q == '0);
  assign ready_o = !full;
  assign valid_o = !empty;
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // a push always lands in a free slot, never on the unread head
  push_not_full_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push |-> (wr_ptr_q != rd_ptr_q) || (cnt_q == '0));

endmodule
